// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_icache
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) sim/icache_golden.txt
	$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  icache_pkg::fetch_req_t          req,
    output logic                            rsp_valid,
    input  logic                            rsp_ready,
    output icache_pkg::fetch_rsp_t          rsp,
    input  logic                            flush,
    input  logic                            hit,
    input  logic [icache_pkg::data_w-1:0]   rd_word,
    output logic                            tag_flush,
    output logic [icache_pkg::index_w-1:0]  lookup_index,
    output logic [icache_pkg::offset_w-1:0] lookup_offset,
    output logic [icache_pkg::tag_w-1:0]    lookup_tag,
    output logic                            install_en,
    output logic                            refill_start,
    output icache_pkg::mem_req_t            refill_addr,
    input  logic                            refill_done,
    output logic [31:0]                     miss_count
);
    import icache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nx;
    fetch_req_t  addr_q;
    logic        flush_pend;
    logic        accept;

    // a flush seen mid-miss waits for idle
    assign tag_flush = (state == st_idle) && (flush || flush_pend);
    assign req_ready = (state == st_idle) && !flush && !flush_pend;
    assign accept    = req_valid && req_ready;

    always_comb
    begin
        state_nx = state;
        case (state)
            st_idle:    if (accept) state_nx = st_lookup;
            st_lookup:  state_nx = hit ? st_respond : st_refill;
            st_refill:  if (refill_done) state_nx = st_install;
            st_install: state_nx = st_lookup;
            st_respond: if (rsp_ready) state_nx = st_idle;
            default:    state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= st_idle;
            flush_pend <= 1'b0;
            miss_count <= '0;
        end
        else
        begin
            state <= state_nx;
            if (tag_flush)
                flush_pend <= 1'b0;
            else if (flush)
                flush_pend <= 1'b1;
            if (refill_start)
                miss_count <= miss_count + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            addr_q <= req;
        if (state == st_lookup && hit)
            rsp.word <= rd_word;
    end

    // in idle the stores read straight from the request
    assign lookup_index  = (state == st_idle) ? req.index : addr_q.index;
    assign lookup_offset = (state == st_idle) ? req.offset : addr_q.offset;
    assign lookup_tag    = (state == st_idle) ? req.tag : addr_q.tag;

    assign install_en   = (state == st_install);
    assign refill_start = (state == st_lookup) && !hit;
    assign refill_addr  = '{tag: addr_q.tag, index: addr_q.index};
    assign rsp_valid    = (state == st_respond);

    a_rsp_hold: assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    ) else $error("fetch response changed before it was taken");

endmodule

`default_nettype wire

// File: hdl/icache_data_store.sv
`timescale 1ns/10ps
`default_nettype none

module icache_data_store (
    input  logic                            clk,
    input  logic [icache_pkg::index_w-1:0]  rd_index,
    input  logic [icache_pkg::offset_w-1:0] rd_offset,
    input  logic                            wr_en,
    input  logic [icache_pkg::index_w-1:0]  wr_index,
    input  logic [icache_pkg::offset_w-1:0] wr_offset,
    input  logic [icache_pkg::data_w-1:0]   wr_word,
    output logic [icache_pkg::data_w-1:0]   rd_word
);
    import icache_pkg::*;

    logic [data_w-1:0] words [num_sets][line_words];

    // refill beats land one word at a time
    always_ff @(posedge clk)
    begin
        if (wr_en)
            words[wr_index][wr_offset] <= wr_word;
    end

    // one cycle read latency
    always_ff @(posedge clk)
    begin
        rd_word <= words[rd_index][rd_offset];
    end

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // geometry
    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int num_sets   = 16;
    localparam int line_words = 4;
    localparam int index_w    = $clog2(num_sets);
    localparam int offset_w   = $clog2(line_words);
    localparam int byte_w     = 2;
    localparam int tag_w      = addr_w - index_w - offset_w - byte_w;

    // fetch address fields from the msb down
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
        logic [byte_w-1:0]   byte_off;
    } fetch_req_t;

    typedef struct packed {
        logic [data_w-1:0] word;
    } fetch_rsp_t;

    // line address without the word offset and byte bits
    typedef struct packed {
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
    } mem_req_t;

    // one refill beat
    typedef struct packed {
        logic [data_w-1:0] word;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_install,
        st_respond
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/icache_refill.sv
`timescale 1ns/10ps
`default_nettype none

module icache_refill (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  icache_pkg::mem_req_t            line_addr,
    output logic                            mem_req_valid,
    input  logic                            mem_req_ready,
    output icache_pkg::mem_req_t            mem_req,
    input  logic                            mem_rsp_valid,
    input  icache_pkg::mem_rsp_t            mem_rsp,
    output logic                            wr_en,
    output logic [icache_pkg::index_w-1:0]  wr_index,
    output logic [icache_pkg::offset_w-1:0] wr_offset,
    output logic [icache_pkg::data_w-1:0]   wr_word,
    output logic                            done
);
    import icache_pkg::*;

    localparam logic [offset_w-1:0] last_beat = offset_w'(line_words - 1);

    logic                busy;
    logic [offset_w-1:0] beat;
    mem_req_t            addr_q;

    always_ff @(posedge clk)
    begin
        if (start)
            addr_q <= line_addr;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy          <= 1'b0;
            mem_req_valid <= 1'b0;
            beat          <= '0;
            done          <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy          <= 1'b1;
                mem_req_valid <= 1'b1;
                beat          <= '0;
            end
            else if (mem_req_valid && mem_req_ready)
                mem_req_valid <= 1'b0;
            // beats come in word order
            if (wr_en)
            begin
                beat <= beat + 1'b1;
                if (beat == last_beat)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    assign mem_req   = addr_q;
    assign wr_en     = busy && mem_rsp_valid;
    assign wr_index  = addr_q.index;
    assign wr_offset = beat;
    assign wr_word   = mem_rsp.word;

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> !busy
    ) else $error("refill started while a line is in flight");

    a_no_stray_beats: assert property (
        @(posedge clk) disable iff (rst) !busy |-> !mem_rsp_valid
    ) else $error("memory beat arrived with no refill pending");

endmodule

`default_nettype wire

// File: hdl/icache_tag_store.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_store (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic [icache_pkg::index_w-1:0] rd_index,
    input  logic [icache_pkg::tag_w-1:0]   cmp_tag,
    input  logic                           wr_en,
    input  logic [icache_pkg::index_w-1:0] wr_index,
    input  logic [icache_pkg::tag_w-1:0]   wr_tag,
    output logic                           hit
);
    import icache_pkg::*;

    logic [tag_w-1:0]    tags [num_sets];
    logic [num_sets-1:0] valid;

    // flush clears every valid bit
    always_ff @(posedge clk)
    begin
        if (rst || flush)
            valid <= '0;
        else if (wr_en)
            valid[wr_index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            tags[wr_index] <= wr_tag;
    end

    // an install to the same set is forwarded into the compare
    always_ff @(posedge clk)
    begin
        if (rst)
            hit <= 1'b0;
        else if (wr_en && wr_index == rd_index)
            hit <= (wr_tag == cmp_tag);
        else
            hit <= valid[rd_index] && (tags[rd_index] == cmp_tag);
    end

    // the controller flushes only from idle
    a_no_install_on_flush: assert property (
        @(posedge clk) disable iff (rst) !(wr_en && flush)
    ) else $error("tag install and flush in the same cycle");

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  icache_pkg::fetch_req_t req,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output icache_pkg::fetch_rsp_t rsp,
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    output icache_pkg::mem_req_t   mem_req,
    input  logic                   mem_rsp_valid,
    input  icache_pkg::mem_rsp_t   mem_rsp,
    input  logic                   flush,
    output logic [31:0]            miss_count
);
    import icache_pkg::*;

    logic                hit;
    logic [data_w-1:0]   rd_word;
    logic                tag_flush;
    logic [index_w-1:0]  lookup_index;
    logic [offset_w-1:0] lookup_offset;
    logic [tag_w-1:0]    lookup_tag;
    logic                install_en;
    logic                refill_start;
    mem_req_t            refill_addr;
    logic                refill_done;
    logic                wr_en;
    logic [index_w-1:0]  wr_index;
    logic [offset_w-1:0] wr_offset;
    logic [data_w-1:0]   wr_word;

    icache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
        .flush(flush), .hit(hit), .rd_word(rd_word), .tag_flush(tag_flush),
        .lookup_index(lookup_index), .lookup_offset(lookup_offset),
        .lookup_tag(lookup_tag), .install_en(install_en),
        .refill_start(refill_start), .refill_addr(refill_addr),
        .refill_done(refill_done), .miss_count(miss_count)
    );

    // install reuses the held lookup index and tag
    icache_tag_store u_tags (
        .clk(clk), .rst(rst), .flush(tag_flush),
        .rd_index(lookup_index), .cmp_tag(lookup_tag),
        .wr_en(install_en), .wr_index(lookup_index), .wr_tag(lookup_tag), .hit(hit)
    );

    icache_data_store u_data (
        .clk(clk), .rd_index(lookup_index), .rd_offset(lookup_offset),
        .wr_en(wr_en), .wr_index(wr_index), .wr_offset(wr_offset),
        .wr_word(wr_word), .rd_word(rd_word)
    );

    icache_refill u_refill (
        .clk(clk), .rst(rst), .start(refill_start), .line_addr(refill_addr),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
        .wr_en(wr_en), .wr_index(wr_index), .wr_offset(wr_offset),
        .wr_word(wr_word), .done(refill_done)
    );

endmodule

`default_nettype wire

// File: sim.f
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_refill.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
sim/tb_mem_model.sv
sim/tb_icache.sv

// File: sim/icache_golden.txt
// op address expected_data expected_miss_count
// F fetches and X flushes with all values in hex
F 00000100 feff0100 00000001
F 00000104 fefb0104 00000001
F 00000108 fef70108 00000001
F 0000010c fef3010c 00000001
F 00000230 fdcf0230 00000002
F 00000234 fdcb0234 00000002
F 0000023c fdc3023c 00000002
F 00000100 feff0100 00000002
F 00001250 edaf1250 00000003
F 00abcd54 32abcd54 00000004
F 00001250 edaf1250 00000005
F 00abcd54 32abcd54 00000006
F 00001258 eda71258 00000007
F 0000125c eda3125c 00000007
F 00000104 fefb0104 00000007
X 00000000 00000000 00000007
F 00000104 fefb0104 00000008
F 00000100 feff0100 00000008
F 00000234 fdcb0234 00000009
F 00000238 fdc70238 00000009
F 8000fff0 000ffff0 0000000a
F 8000fffc 0003fffc 0000000a
F 12345678 a9875678 0000000b
F 12345670 a98f5670 0000000b
X 00000000 00000000 0000000b
F 12345674 a98b5674 0000000c
F 8000fff4 000bfff4 0000000d
F 00000100 feff0100 0000000e

// File: sim/tb_icache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam logic [31:0] seed = 32'd11394;
    localparam int max_wait = 300;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    fetch_req_t  req;
    logic        rsp_valid;
    logic        rsp_ready;
    fetch_rsp_t  rsp;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_req_t    mem_req;
    logic        mem_rsp_valid;
    mem_rsp_t    mem_rsp;
    logic        flush;
    logic [31:0] miss_count;
    logic [31:0] rng;
    logic [31:0] last_count;

    icache_top dut (.*);

    tb_mem_model #(.seed(seed)) mem (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic stop_with_failure(input string why);
        $display("test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            stop_with_failure({"wrong value on ", name});
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        rng = xorshift(rng);
        // rsp_ready low about a quarter of the time
        rsp_ready <= (rng[9:8] != 2'b00);
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, input logic [31:0] exp_data,
                                   input logic [31:0] exp_count);
        int cycles;
        int first_valid;

        first_valid = 0;
        cycles      = 0;
        req_valid  <= 1'b1;
        req        <= addr;
        do
        begin
            step_clock();
            cycles++;
            if (cycles > max_wait)
                stop_with_failure("timed out waiting for req_ready");
        end while (!req_ready);
        req_valid <= 1'b0;

        // count cycles from acceptance to the response
        cycles = 0;
        do
        begin
            step_clock();
            cycles++;
            if (cycles > max_wait)
                stop_with_failure("timed out waiting for the fetch response");
            check_equal("req_ready", 32'(req_ready), 32'd0);
            if (rsp_valid && first_valid == 0)
                first_valid = cycles;
        end while (!(rsp_valid && rsp_ready));

        check_equal("rsp", rsp.word, exp_data);
        check_equal("miss_count", miss_count, exp_count);
        if (exp_count == last_count)
            check_equal("hit_latency", 32'(first_valid), 32'd2);
        last_count = exp_count;
    endtask

    task automatic apply_flush(input logic [31:0] exp_count);
        flush <= 1'b1;
        step_clock();
        // nothing is accepted while the flush is applied
        check_equal("req_ready", 32'(req_ready), 32'd0);
        flush <= 1'b0;
        step_clock();
        check_equal("miss_count", miss_count, exp_count);
        last_count = exp_count;
    endtask

    initial
    begin
        int          fd;
        int          fields;
        int          ops;
        string       line;
        byte         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] count;

        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        flush      = 1'b0;
        rng        = seed;
        last_count = '0;
        ops        = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("sim/icache_golden.txt", "r");
        if (fd == 0)
            stop_with_failure("could not open the golden file");
        while ($fgets(line, fd) != 0)
        begin
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "/")
                continue;
            op = line.getc(0);
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", addr, data, count);
            if (fields != 3)
                stop_with_failure("a golden file line has too few fields");
            if (op == "F")
                fetch_and_check(addr, data, count);
            else if (op == "X")
                apply_flush(count);
            else
                stop_with_failure("unknown op in the golden file");
            ops++;
        end
        $fclose(fd);
        if (ops == 0)
            stop_with_failure("the golden file holds no operations");
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] seed = 32'd1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_req_valid,
    output logic                 mem_req_ready,
    input  icache_pkg::mem_req_t mem_req,
    output logic                 mem_rsp_valid,
    output icache_pkg::mem_rsp_t mem_rsp
);
    import icache_pkg::*;

    logic        ready_q = 1'b0;
    logic        valid_q = 1'b0;
    logic [31:0] word_q  = '0;
    logic        busy    = 1'b0;
    logic [1:0]  beat    = '0;
    logic [1:0]  gap     = '0;
    mem_req_t    line_q  = '0;
    logic [31:0] rng     = seed;

    // upper half is the inverted low half of the byte address
    function automatic logic [31:0] rule_word(input logic [31:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    always @(posedge clk)
    begin
        rng = xorshift(rng);
        valid_q <= 1'b0;
        if (rst)
        begin
            ready_q <= 1'b0;
            busy    <= 1'b0;
        end
        else if (!busy)
        begin
            if (mem_req_valid && ready_q)
            begin
                busy    <= 1'b1;
                line_q  <= mem_req;
                beat    <= 2'd0;
                gap     <= rng[1:0];
                ready_q <= 1'b0;
            end
            else
                ready_q <= (rng[3:2] != 2'b00);
        end
        // 0 to 3 idle cycles before each beat
        else if (gap != 2'd0)
            gap <= gap - 2'd1;
        else
        begin
            valid_q <= 1'b1;
            word_q  <= rule_word({line_q, beat, 2'b00});
            beat    <= beat + 2'd1;
            gap     <= rng[1:0];
            if (beat == 2'd3)
                busy <= 1'b0;
        end
    end

    assign mem_req_ready = ready_q;
    assign mem_rsp_valid = valid_q;
    assign mem_rsp.word  = word_q;

endmodule

`default_nettype wire
